/* verilog/mips_exec_pkg.sv */
`default_nettype none

package mips_exec_pkg;

    // APB bus widths.
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Register file geometry.
    localparam int REG_AW  = 5;  // Register index width.
    localparam int REG_NUM = 32; // Number of general registers.

    // Address map.
    localparam logic [APB_ADDR_W-1:0] ADDR_INSTR    = 8'h00; // Instruction port.
    localparam logic [APB_ADDR_W-1:0] ADDR_REG_BASE = 8'h80; // Register window, 4 bytes apart.

    // Opcodes.
    localparam logic [5:0] OP_RTYPE = 6'h00; // Special, decoded by funct.
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTIU = 6'h0B;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_XORI  = 6'h0E;

    // Funct codes for R-type.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    // ALU control codes.
    localparam logic [3:0] ALU_AND = 4'b0000;
    localparam logic [3:0] ALU_OR  = 4'b0001;
    localparam logic [3:0] ALU_ADD = 4'b0010;
    localparam logic [3:0] ALU_SUB = 4'b0110;
    localparam logic [3:0] ALU_SLT = 4'b0111; // Unsigned compare.
    localparam logic [3:0] ALU_XOR = 4'b1100;
    localparam logic [3:0] ALU_SLL = 4'b1101;
    localparam logic [3:0] ALU_SRL = 4'b1110; // Logical shift.

    // One instruction word, two field views.
    typedef union packed {
        // R-type fields.
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        // I-type fields.
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_u;

endpackage

`default_nettype wire

/* verilog/alu_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decoder import mips_exec_pkg::*; (
    input  instr_u     instr,       // Latched instruction word.
    output logic [3:0] alu_control, // ALU operation.
    output logic       alu_src,     // High selects the immediate.
    output logic [4:0] dest_addr,   // Register to write.
    output logic       instr_legal  // Low for unsupported encodings.
);

    always_comb begin
        // Defaults describe an illegal word.
        alu_control = ALU_ADD;
        alu_src     = 1'b0;
        dest_addr   = '0;
        instr_legal = 1'b0;

        case (instr.r.opcode)
            OP_RTYPE: begin
                // R-type, result goes to rd.
                dest_addr   = instr.r.rd;
                instr_legal = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: alu_control = ALU_ADD;
                    FN_SUBU: alu_control = ALU_SUB;
                    FN_AND:  alu_control = ALU_AND;
                    FN_OR:   alu_control = ALU_OR;
                    FN_XOR:  alu_control = ALU_XOR;
                    FN_SLTU: alu_control = ALU_SLT;
                    FN_SLL:  alu_control = ALU_SLL;
                    FN_SRL:  alu_control = ALU_SRL;
                    default: instr_legal = 1'b0; // Unknown funct.
                endcase
            end
            OP_ADDIU, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                // I-type, result goes to rt.
                dest_addr   = instr.i.rt;
                alu_src     = 1'b1;
                instr_legal = 1'b1;
                case (instr.i.opcode)
                    OP_ADDIU: alu_control = ALU_ADD;
                    OP_SLTIU: alu_control = ALU_SLT;
                    OP_ANDI:  alu_control = ALU_AND;
                    OP_ORI:   alu_control = ALU_OR;
                    default:  alu_control = ALU_XOR; // Only xori is left.
                endcase
            end
            default: begin
                instr_legal = 1'b0; // Opcode not supported.
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import mips_exec_pkg::*; (
    input  logic [31:0] data_a,      // From rs.
    input  logic [31:0] data_b,      // From rt.
    input  logic [15:0] imme,        // Raw immediate field.
    input  logic        alu_src,     // Operand B source.
    input  logic [3:0]  alu_control,
    input  logic [4:0]  shamt,
    output logic [31:0] alu_result
);

    logic [31:0] zero_extimm;
    logic [31:0] sign_extimm;
    logic [31:0] real_imme;
    logic [31:0] real_data_b;

    logic [31:0] add_result;
    logic [31:0] sub_result;
    logic [31:0] and_result;
    logic [31:0] or_result;
    logic [31:0] lessthan_result;
    logic [31:0] xor_result;
    logic [31:0] sll_result;
    logic [31:0] srl_result;

    // Both immediate extensions.
    assign zero_extimm = {16'h0000, imme};
    assign sign_extimm = {{16{imme[15]}}, imme};

    // Logic ops take the zero-extended form.
    always_comb begin
        if (alu_control == ALU_AND || alu_control == ALU_OR || alu_control == ALU_XOR) begin
            real_imme = zero_extimm;
        end else begin
            real_imme = sign_extimm; // Add and compare sign-extend.
        end
    end

    assign real_data_b = alu_src ? real_imme : data_b; // Operand B mux.

    // Every candidate result in parallel.
    assign add_result      = data_a + real_data_b;
    assign sub_result      = data_a - real_data_b;
    assign and_result      = data_a & real_data_b;
    assign or_result       = data_a | real_data_b;
    assign xor_result      = data_a ^ real_data_b;
    assign lessthan_result = (data_a < real_data_b) ? 32'd1 : 32'd0; // Unsigned.
    assign sll_result      = real_data_b << shamt;
    assign srl_result      = real_data_b >> shamt; // Fills with zeros.

    // Result select.
    always_comb begin
        case (alu_control)
            ALU_ADD: alu_result = add_result;
            ALU_SUB: alu_result = sub_result;
            ALU_AND: alu_result = and_result;
            ALU_OR:  alu_result = or_result;
            ALU_SLT: alu_result = lessthan_result;
            ALU_XOR: alu_result = xor_result;
            ALU_SLL: alu_result = sll_result;
            ALU_SRL: alu_result = srl_result;
            default: alu_result = 32'h0000_0000; // Undefined code.
        endcase
    end

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import mips_exec_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] rs_addr, // Read port A.
    input  logic [REG_AW-1:0] rt_addr, // Read port B.
    output logic [31:0]       rs_data,
    output logic [31:0]       rt_data,
    input  logic              wr_en,
    input  logic [REG_AW-1:0] wr_addr,
    input  logic [31:0]       wr_data
);

    logic [31:0] regs [REG_NUM]; // General registers.

    // Register 0 is never written.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < REG_NUM; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational reads.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

/* verilog/apb_exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_exec_ctrl import mips_exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // APB slave.
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Instruction side.
    output instr_u                instr,
    input  logic                  instr_legal,
    input  logic [REG_AW-1:0]     dest_addr,
    input  logic [31:0]           alu_result,
    // Register file side.
    output logic [REG_AW-1:0]     rs_addr,
    output logic [REG_AW-1:0]     rt_addr,
    input  logic [31:0]           rs_data,
    output logic                  wr_en,
    output logic [REG_AW-1:0]     wr_addr,
    output logic [31:0]           wr_data
);

    logic                  access;     // Access phase of a transfer.
    logic                  sel_instr;  // Instruction port hit.
    logic                  sel_reg;    // Register window hit.
    logic [APB_ADDR_W-1:0] reg_off;    // Offset into the window.
    logic [REG_AW-1:0]     win_idx;    // Register index from paddr.
    logic                  instr_wr;   // First access cycle of an instruction write.
    logic                  exec_phase; // Second cycle, instruction executes.

    assign access = psel && penable;

    // Address decode.
    assign reg_off   = paddr - ADDR_REG_BASE;
    assign sel_instr = (paddr == ADDR_INSTR);
    assign sel_reg   = (paddr >= ADDR_REG_BASE) && (reg_off[1:0] == 2'b00); // Word aligned only.
    assign win_idx   = reg_off[REG_AW+1:2];

    // Instruction write needs one wait state.
    assign instr_wr = access && pwrite && sel_instr && !exec_phase;

    // Instruction register and execute flag.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exec_phase <= 1'b0;
            instr      <= '0; // Reads as sll r0,r0,0.
        end else begin
            exec_phase <= instr_wr; // Set for exactly one cycle.
            if (instr_wr) begin
                instr <= pwdata; // Latched in first access cycle.
            end
        end
    end

    // Ready everywhere except the latch cycle.
    assign pready = access && !instr_wr;

    // Error on illegal word or unmapped address.
    always_comb begin
        if (!pready) begin
            pslverr = 1'b0; // Only valid with pready.
        end else if (exec_phase) begin
            pslverr = !instr_legal;
        end else begin
            pslverr = !(sel_instr || sel_reg);
        end
    end

    // Read data mux.
    always_comb begin
        if (sel_instr) begin
            prdata = instr;
        end else if (sel_reg) begin
            prdata = rs_data; // Window reads share port A.
        end else begin
            prdata = '0;
        end
    end

    // Read addresses.
    // Port A follows the instruction while executing, else the window.
    assign rs_addr = exec_phase ? instr.r.rs : win_idx;
    assign rt_addr = instr.r.rt; // Port B only used by execution.

    // Write port mux.
    always_comb begin
        if (exec_phase) begin
            wr_en   = access && instr_legal; // Result at closing edge.
            wr_addr = dest_addr;
            wr_data = alu_result;
        end else begin
            wr_en   = access && pwrite && sel_reg; // Zero wait window write.
            wr_addr = win_idx;
            wr_data = pwdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/mips_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_exec_top import mips_exec_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    instr_u              instr;       // Latched instruction.
    logic                instr_legal;
    logic [REG_AW-1:0]   dest_addr;
    logic [3:0]          alu_control;
    logic                alu_src;
    logic [31:0]         alu_result;
    logic [REG_AW-1:0]   rs_addr;
    logic [REG_AW-1:0]   rt_addr;
    logic [31:0]         rs_data;
    logic [31:0]         rt_data;
    logic                wr_en;
    logic [REG_AW-1:0]   wr_addr;
    logic [31:0]         wr_data;

    // APB slave and sequencer.
    apb_exec_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .instr       (instr),
        .instr_legal (instr_legal),
        .dest_addr   (dest_addr),
        .alu_result  (alu_result),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    alu_decoder u_dec (
        .instr       (instr),
        .alu_control (alu_control),
        .alu_src     (alu_src),
        .dest_addr   (dest_addr),
        .instr_legal (instr_legal)
    );

    // Immediate and shift amount come straight from the word.
    alu u_alu (
        .data_a      (rs_data),
        .data_b      (rt_data),
        .imme        (instr.i.imm),
        .alu_src     (alu_src),
        .alu_control (alu_control),
        .shamt       (instr.r.shamt),
        .alu_result  (alu_result)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule

`default_nettype wire

/* verif/mips_exec_model.svh */
logic [31:0] model_regs [32]; // Expected register contents.
logic [31:0] lfsr_state;      // Galois LFSR state.

// One LFSR step per bit.
function automatic logic next_rand_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'hD000_0001; // Taps 32, 31, 29, 1.
    end
    return out_bit;
endfunction

// N fresh bits, right aligned.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[30:0], next_rand_bit()};
    end
    return v;
endfunction

function automatic void model_write(input logic [4:0] idx, input logic [31:0] val);
    if (idx != 5'd0) begin
        model_regs[idx] = val; // r0 stays zero.
    end
endfunction

// Runs one word on the model. Returns low for an unsupported encoding.
function automatic logic model_execute(input logic [31:0] word);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] res;
    logic        legal;
    a     = model_regs[word[25:21]]; // rs.
    b     = model_regs[word[20:16]]; // rt.
    sext  = {{16{word[15]}}, word[15:0]};
    zext  = {16'h0000, word[15:0]};
    res   = '0;
    legal = 1'b1;
    case (word[31:26])
        OP_RTYPE: begin
            case (word[5:0])
                FN_ADDU: res = a + b;
                FN_SUBU: res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                FN_SLL:  res = b << word[10:6];
                FN_SRL:  res = b >> word[10:6]; // Logical.
                default: legal = 1'b0;
            endcase
        end
        OP_ADDIU: res = a + sext;
        OP_SLTIU: res = (a < sext) ? 32'd1 : 32'd0; // Sign-extend, compare unsigned.
        OP_ANDI:  res = a & zext;
        OP_ORI:   res = a | zext;
        OP_XORI:  res = a ^ zext;
        default:  legal = 1'b0;
    endcase
    if (legal) begin
        // rd for R-type, rt for I-type.
        model_write((word[31:26] == OP_RTYPE) ? word[15:11] : word[20:16], res);
    end
    return legal;
endfunction

/* verif/mips_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_exec_tb import mips_exec_pkg::*; ();

    localparam int NUM_RTYPE  = 300;
    localparam int NUM_ITYPE  = 300;
    localparam int NUM_BAD    = 20; // Per error kind.
    // Reset sweep, two loads, 3 transfers per instruction, errors, final sweep.
    localparam int NUM_XFER   = 32 + 128 + 3 * (NUM_RTYPE + NUM_ITYPE) + 6 * NUM_BAD + 32;
    localparam int MAX_CYCLES = 4 * NUM_XFER + 100;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    int          cycle_count = 0;
    int          error_count = 0;

    `include "mips_exec_model.svh"

    mips_exec_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #5 clk = ~clk; // 10 ns period.

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a transfer never completed.", cycle_count);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // One APB transfer. Counts access cycles with pready low.
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err, output int waits);
        @(negedge clk);
        psel    = 1'b1; // Setup phase.
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1; // Access phase.
        waits   = 0;
        #1;
        while (pready !== 1'b1) begin
            waits++;
            @(negedge clk);
            #1; // Sample well ahead of the rising edge.
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk); // Transfer closes here.
    endtask

    task automatic reg_write(input logic [4:0] idx, input logic [31:0] val);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_transfer(1'b1, ADDR_REG_BASE | {1'b0, idx, 2'b00}, val, rdata, err, waits);
        check_value("wait_states", 32'd0, 32'(waits));
        check_value("pslverr", 32'd0, {31'd0, err});
        model_write(idx, val);
    endtask

    task automatic reg_check(input logic [4:0] idx);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_transfer(1'b0, ADDR_REG_BASE | {1'b0, idx, 2'b00}, 32'd0, rdata, err, waits);
        check_value("wait_states", 32'd0, 32'(waits));
        check_value("pslverr", 32'd0, {31'd0, err});
        check_value("prdata", model_regs[idx], rdata);
    endtask

    // Instruction write, then read back of the instruction port.
    task automatic exec_instr(input logic [31:0] word);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        logic        legal;
        legal = model_execute(word);
        apb_transfer(1'b1, ADDR_INSTR, word, rdata, err, waits);
        check_value("wait_states", 32'd1, 32'(waits)); // Latch cycle, then execute.
        check_value("pslverr", {31'd0, !legal}, {31'd0, err});
        apb_transfer(1'b0, ADDR_INSTR, 32'd0, rdata, err, waits);
        check_value("wait_states", 32'd0, 32'(waits));
        check_value("pslverr", 32'd0, {31'd0, err});
        check_value("prdata", word, rdata);
    endtask

    // Unmapped address, both directions.
    task automatic bad_access(input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        int          waits;
        apb_transfer(1'b1, addr, rand_bits(32), rdata, err, waits);
        check_value("wait_states", 32'd0, 32'(waits));
        check_value("pslverr", 32'd1, {31'd0, err});
        apb_transfer(1'b0, addr, 32'd0, rdata, err, waits);
        check_value("wait_states", 32'd0, 32'(waits));
        check_value("pslverr", 32'd1, {31'd0, err});
    endtask

    task automatic load_and_verify();
        for (int i = 0; i < 32; i++) begin
            reg_write(5'(i), rand_bits(32)); // r0 write is dropped.
        end
        for (int i = 0; i < 32; i++) begin
            reg_check(5'(i));
        end
    endtask

    function automatic logic [5:0] pick_funct(input logic [2:0] s);
        case (s)
            3'd0:    return FN_ADDU;
            3'd1:    return FN_SUBU;
            3'd2:    return FN_AND;
            3'd3:    return FN_OR;
            3'd4:    return FN_XOR;
            3'd5:    return FN_SLTU;
            3'd6:    return FN_SLL;
            default: return FN_SRL;
        endcase
    endfunction

    function automatic logic [5:0] pick_opcode(input logic [2:0] s);
        case (s)
            3'd0, 3'd5: return OP_ADDIU;
            3'd1:       return OP_SLTIU;
            3'd2:       return OP_ANDI;
            3'd3, 3'd6: return OP_ORI;
            default:    return OP_XORI;
        endcase
    endfunction

    initial begin
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [7:0]  addr;
        clk        = 1'b0;
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'd77175;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 32; i++) begin
            reg_check(5'(i)); // Reset state.
        end
        load_and_verify();

        for (int n = 0; n < NUM_RTYPE; n++) begin
            rs = 5'(rand_bits(5));
            rt = 5'(rand_bits(5));
            rd = 5'(rand_bits(5));
            fn = pick_funct(3'(rand_bits(3)));
            exec_instr({OP_RTYPE, rs, rt, rd, 5'(rand_bits(5)), fn});
            reg_check(rd);
        end

        load_and_verify(); // Fresh operands for I-type.
        for (int n = 0; n < NUM_ITYPE; n++) begin
            rs = 5'(rand_bits(5));
            rt = 5'(rand_bits(5));
            op = pick_opcode(3'(rand_bits(3)));
            exec_instr({op, rs, rt, 16'(rand_bits(16))});
            reg_check(rt);
        end

        for (int n = 0; n < NUM_BAD; n++) begin
            op = 6'(rand_bits(6));
            while (op inside {OP_RTYPE, OP_ADDIU, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI}) begin
                op = 6'(rand_bits(6));
            end
            exec_instr({op, 26'(rand_bits(26))});
            fn = 6'(rand_bits(6));
            while (fn inside {FN_SLL, FN_SRL, FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                              FN_SLTU}) begin
                fn = 6'(rand_bits(6));
            end
            exec_instr({OP_RTYPE, 20'(rand_bits(20)), fn});
            addr = 8'(rand_bits(8));
            while (addr == ADDR_INSTR || (addr >= ADDR_REG_BASE && addr[1:0] == 2'b00)) begin
                addr = 8'(rand_bits(8)); // Skip mapped addresses.
            end
            bad_access(addr);
        end
        for (int i = 0; i < 32; i++) begin
            reg_check(5'(i)); // Nothing changed by the errors.
        end

        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mips_exec.f */
+incdir+verif
verilog/mips_exec_pkg.sv
verilog/alu_decoder.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/apb_exec_ctrl.sv
verilog/mips_exec_top.sv
verif/mips_exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the MIPS execute testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f mips_exec.f \
    --top-module mips_exec_tb \
    -Mdir obj_dir

# The simulator's own status is ignored; the pass line decides.
sim_out=$(./obj_dir/Vmips_exec_tb 2>&1 || true)
echo "$sim_out"

if grep -q '^>>> PASS$' <<< "$sim_out"; then
    exit 0
fi
exit 1
